/* src.f */
src/a2600_cfg_pkg.sv
src/a2600_ctrl_pkg.sv
src/mouse_tracker.sv
src/paddle_port.sv
src/console_switches.sv
src/cart_detect.sv
src/a2600_input_top.sv
bench/tb_a2600_input.sv

/* Bender.yml */
package:
  name: a2600_input

sources:
  - src/a2600_cfg_pkg.sv
  - src/a2600_ctrl_pkg.sv
  - src/mouse_tracker.sv
  - src/paddle_port.sv
  - src/console_switches.sv
  - src/cart_detect.sv
  - src/a2600_input_top.sv
  - target: test
    files:
      - bench/tb_a2600_input.sv

/* bench/tb_a2600_input.sv */
// Directed testbench for the 2600 controller and cartridge glue
// Runs paddle, swap, console panel, pause and cartridge tests against the top level
`timescale 1ns/1ps
`default_nettype none

module tb_a2600_input;
	import a2600_ctrl_pkg::*;
	import a2600_cfg_pkg::*;

	localparam int CLK_HALF   = 20;
	localparam int MAX_CYCLES = 2000;

	logic        clk_sys;
	logic        reset;
	pad_t        pad_0;
	pad_t        pad_1;
	logic [15:0] stick_0;
	logic [15:0] stick_1;
	logic [7:0]  knob_0;
	logic [7:0]  knob_1;
	mouse_t      mouse;
	cfg_t        cfg;
	logic        download;
	logic [31:0] file_ext;
	player_t     player_1;
	player_t     player_2;
	console_t    console;
	cart_t       cart;

	string test_name;
	int    cycle_count;

	a2600_input_top a2600_input_top_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pad_0    (pad_0),
		.pad_1    (pad_1),
		.stick_0  (stick_0),
		.stick_1  (stick_1),
		.knob_0   (knob_0),
		.knob_1   (knob_1),
		.mouse    (mouse),
		.cfg      (cfg),
		.download (download),
		.file_ext (file_ext),
		.player_1 (player_1),
		.player_2 (player_2),
		.console  (console),
		.cart     (cart)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
			abort_run($sformatf("timeout: run went past %0d clock cycles", MAX_CYCLES));
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		abort_run($sformatf("error: %s %s expected %0h actual %0h",
			test_name, what, expected, actual));
	endtask

	// Every drive and every check happens on the falling edge
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		wait_cycles(5);
		reset = 1'b0;
		wait_cycles(1);
	endtask

	// MSB flip followed by a full complement leaves only the low seven bits flipped
	function automatic logic [7:0] knob_paddle(input logic [7:0] k, input logic inv);
		return k ^ (inv ? 8'h7f : 8'h80);
	endfunction

	task automatic send_mouse_dx(input logic [8:0] delta);
		mouse.sign_x = delta[8];
		mouse.dx     = delta[7:0];
		mouse.strobe = ~mouse.strobe;
		wait_cycles(2);
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic test_knob();
		logic [7:0] k0;
		logic [7:0] k1;
		test_name = "knob";
		for (int inv = 0; inv < 2; inv++) begin
			k0 = 8'($urandom);
			k1 = 8'($urandom);
			knob_0 = k0;
			knob_1 = k1;
			cfg.invert_paddle = inv[0];
			wait_cycles(6);
			assert (player_1.paddle == knob_paddle(k0, inv[0]))
				else report_mismatch("port 0 paddle", knob_paddle(k0, inv[0]), player_1.paddle);
			assert (player_2.paddle == knob_paddle(k1, inv[0]))
				else report_mismatch("port 1 paddle", knob_paddle(k1, inv[0]), player_2.paddle);
		end
		cfg.invert_paddle = 1'b0;
	endtask

	task automatic test_stick_mouse();
		logic [7:0] x;
		logic [7:0] y;
		test_name = "stick";
		// Y above threshold, X below
		y = 8'(101 + $urandom % 27);
		x = 8'($urandom % 101);
		stick_0 = {y, x};
		pad_0.stick_btn = 1'b1;
		wait_cycles(6);
		assert (player_1.paddle == y) else report_mismatch("y axis", y, player_1.paddle);
		assert (player_1.paddle_btn_n == 1'b0)
			else report_mismatch("stick button", 1'b0, player_1.paddle_btn_n);
		pad_0.stick_btn = 1'b0;
		// Y negative, X above threshold
		x = 8'(101 + $urandom % 27);
		y = 8'h80 | 8'($urandom % 128);
		stick_0 = {y, x};
		wait_cycles(6);
		assert (player_1.paddle == x) else report_mismatch("x axis", x, player_1.paddle);

		test_name = "mouse";
		repeat (3) send_mouse_dx(9'sd40);
		wait_cycles(6);
		assert (player_2.paddle == 8'd30)
			else report_mismatch("clamped steps", 8'd30, player_2.paddle);
		repeat (20) send_mouse_dx(-9'sd100);
		wait_cycles(6);
		assert (player_2.paddle == 8'h80)
			else report_mismatch("saturated position", 8'h80, player_2.paddle);
	endtask

	task automatic test_swap();
		logic [7:0] k0;
		test_name = "swap";
		// Port 0 back to its knob, port 1 stays on the mouse at -128
		k0 = 8'($urandom);
		knob_0 = k0;
		pad_0.paddle_btn = 1'b1;
		wait_cycles(2);
		pad_0.paddle_btn = 1'b0;
		wait_cycles(6);
		pad_0.fire       = 1'b1;
		pad_0.fire2      = 1'b1;
		pad_0.up         = 1'b1;
		pad_0.paddle_btn = 1'b1;
		cfg.swap         = 1'b1;
		wait_cycles(2);
		assert (player_2.fire_n == 1'b0) else report_mismatch("p2 fire", 1'b0, player_2.fire_n);
		assert (player_2.fire2_n == 1'b0)
			else report_mismatch("p2 fire2", 1'b0, player_2.fire2_n);
		assert (player_2.dir_n == 4'b1110) else report_mismatch("p2 dir", 4'b1110, player_2.dir_n);
		assert (player_2.paddle_btn_n == 1'b0)
			else report_mismatch("p2 paddle button", 1'b0, player_2.paddle_btn_n);
		assert (player_1.fire_n == 1'b1) else report_mismatch("p1 fire", 1'b1, player_1.fire_n);
		assert (player_1.fire2_n == 1'b1)
			else report_mismatch("p1 fire2", 1'b1, player_1.fire2_n);
		assert (player_1.paddle_btn_n == 1'b1)
			else report_mismatch("p1 paddle button", 1'b1, player_1.paddle_btn_n);
		assert (player_1.paddle == 8'h80) else report_mismatch("p1 paddle", 8'h80, player_1.paddle);
		assert (player_2.paddle == knob_paddle(k0, 1'b0))
			else report_mismatch("p2 paddle", knob_paddle(k0, 1'b0), player_2.paddle);
		cfg.swap = 1'b0;
		wait_cycles(1);
		assert (player_1.fire_n == 1'b0) else report_mismatch("p1 fire", 1'b0, player_1.fire_n);
		assert (player_1.fire2_n == 1'b0)
			else report_mismatch("p1 fire2", 1'b0, player_1.fire2_n);
		assert (player_1.dir_n == 4'b1110) else report_mismatch("p1 dir", 4'b1110, player_1.dir_n);
		assert (player_1.paddle_btn_n == 1'b0)
			else report_mismatch("p1 paddle button", 1'b0, player_1.paddle_btn_n);
		assert (player_2.paddle_btn_n == 1'b1)
			else report_mismatch("p2 paddle button", 1'b1, player_2.paddle_btn_n);
		assert (player_1.paddle == knob_paddle(k0, 1'b0))
			else report_mismatch("p1 paddle", knob_paddle(k0, 1'b0), player_1.paddle);
		assert (player_2.paddle == 8'h80) else report_mismatch("p2 paddle", 8'h80, player_2.paddle);
		pad_0.fire       = 1'b0;
		pad_0.fire2      = 1'b0;
		pad_0.up         = 1'b0;
		pad_0.paddle_btn = 1'b0;
		wait_cycles(1);
	endtask

	task automatic test_console();
		test_name = "console";
		apply_reset();
		assert (console.color == 1'b1) else report_mismatch("reset color", 1'b1, console.color);
		assert (console.dif == 2'b00) else report_mismatch("reset dif", 2'b00, console.dif);
		pad_1.sw_color = 1'b1;
		wait_cycles(2);
		pad_1.sw_color = 1'b0;
		wait_cycles(2);
		assert (console.color == 1'b0) else report_mismatch("color toggle", 1'b0, console.color);
		pad_0.sw_dif1 = 1'b1;
		wait_cycles(2);
		pad_0.sw_dif1 = 1'b0;
		wait_cycles(2);
		assert (console.dif == 2'b01) else report_mismatch("dif toggle", 2'b01, console.dif);
		pad_1.start = 1'b1;
		wait_cycles(1);
		assert (console.start_n == 1'b0) else report_mismatch("start pad 1", 1'b0, console.start_n);
		pad_1.start = 1'b0;
		pad_0.start = 1'b1;
		wait_cycles(1);
		assert (console.start_n == 1'b0) else report_mismatch("start pad 0", 1'b0, console.start_n);
		pad_0.start = 1'b0;
		wait_cycles(1);
		assert (console.start_n == 1'b1) else report_mismatch("start idle", 1'b1, console.start_n);
		pad_0.select = 1'b1;
		wait_cycles(1);
		assert (console.select_n == 1'b0)
			else report_mismatch("select pad 0", 1'b0, console.select_n);
		pad_0.select = 1'b0;
		wait_cycles(1);
		assert (console.select_n == 1'b1)
			else report_mismatch("select idle", 1'b1, console.select_n);
	endtask

	task automatic press_pause(input logic expected, input string what);
		pad_0.pause = 1'b1;
		wait_cycles(4);
		assert (console.pause == expected) else report_mismatch(what, expected, console.pause);
		pad_0.pause = 1'b0;
		wait_cycles(3);
	endtask

	task automatic test_pause();
		test_name = "pause";
		press_pause(1'b1, "first press");
		press_pause(1'b0, "second press");
		press_pause(1'b1, "third press");
		apply_reset();
		assert (console.pause == 1'b0) else report_mismatch("after reset", 1'b0, console.pause);
	endtask

	task automatic load_cart(input string what, input logic [31:0] ext, input sc_mode_e mode,
		input bank_e exp_bank, input logic exp_sc);
		file_ext    = ext;
		cfg.sc_mode = mode;
		wait_cycles(1);
		download = 1'b1;
		wait_cycles(4);
		assert (cart.bank == exp_bank) else report_mismatch({what, " bank"}, exp_bank, cart.bank);
		assert (cart.superchip == exp_sc)
			else report_mismatch({what, " superchip"}, exp_sc, cart.superchip);
		download = 1'b0;
		wait_cycles(2);
	endtask

	task automatic test_cart();
		test_name = "cart";
		load_cart(".F6", ".F6", sc_auto, bs_f6, 1'b0);
		load_cart(".E7S", ".E7S", sc_auto, bs_e7, 1'b1);
		load_cart(".XY", ".XY", sc_auto, bs_auto, 1'b0);
		// Trailing S has no effect while the Super Chip is forced off
		load_cart(".F8S", ".F8S", sc_disable, bs_f8, 1'b0);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		void'($urandom(8251));
		cycle_count = 0;
		reset       = 1'b1;
		pad_0       = '0;
		pad_1       = '0;
		stick_0     = '0;
		stick_1     = '0;
		knob_0      = '0;
		knob_1      = '0;
		mouse       = '0;
		cfg         = '{swap: 1'b0, invert_paddle: 1'b0, sc_mode: sc_auto};
		download    = 1'b0;
		file_ext    = '0;
		apply_reset();

		test_knob();
		test_stick_mouse();
		test_swap();
		test_console();
		test_pause();
		test_cart();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/a2600_input_top.sv */
// Controller and cartridge glue for the 2600 core: two paddle ports, panel, cart type
// Player outputs are active low and follow the swap setting
`timescale 1ns/1ps
`default_nettype none

module a2600_input_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  a2600_ctrl_pkg::pad_t     pad_0,
	input  a2600_ctrl_pkg::pad_t     pad_1,
	input  logic [15:0]              stick_0,
	input  logic [15:0]              stick_1,
	input  logic [7:0]               knob_0,
	input  logic [7:0]               knob_1,
	input  a2600_ctrl_pkg::mouse_t   mouse,
	input  a2600_cfg_pkg::cfg_t      cfg,
	input  logic                     download,
	input  logic [31:0]              file_ext,
	output a2600_ctrl_pkg::player_t  player_1,
	output a2600_ctrl_pkg::player_t  player_2,
	output a2600_ctrl_pkg::console_t console,
	output a2600_cfg_pkg::cart_t     cart
);
	import a2600_ctrl_pkg::*;

	logic [7:0] paddle_0;
	logic [7:0] paddle_1;
	logic       button_0;
	logic       button_1;
	player_t    port_0;
	player_t    port_1;

	// Active-low view of one port as the console expects it
	function automatic player_t map_player(input pad_t pad, input logic btn,
		input logic [7:0] value);
		player_t p;
		p.dir_n        = ~{pad.right, pad.left, pad.down, pad.up};
		p.fire_n       = ~pad.fire;
		p.fire2_n      = ~pad.fire2;
		p.paddle_btn_n = ~btn;
		p.paddle       = value;
		return p;
	endfunction

	// ========================================
	// Paddle ports, mouse on port 1 only
	// ========================================
	paddle_port #(.has_mouse(1'b0)) u_port_0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pad     (pad_0),
		.stick   (stick_0),
		.knob    (knob_0),
		.mouse   ('0),
		.invert  (cfg.invert_paddle),
		.paddle  (paddle_0),
		.button  (button_0)
	);

	paddle_port #(.has_mouse(1'b1)) u_port_1 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pad     (pad_1),
		.stick   (stick_1),
		.knob    (knob_1),
		.mouse   (mouse),
		.invert  (cfg.invert_paddle),
		.paddle  (paddle_1),
		.button  (button_1)
	);

	console_switches u_console (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pad_0   (pad_0),
		.pad_1   (pad_1),
		.console (console)
	);

	cart_detect u_cart (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.download (download),
		.file_ext (file_ext),
		.sc_mode  (cfg.sc_mode),
		.cart     (cart)
	);

	// Swap routing
	assign port_0   = map_player(pad_0, button_0, paddle_0);
	assign port_1   = map_player(pad_1, button_1, paddle_1);
	assign player_1 = cfg.swap ? port_1 : port_0;
	assign player_2 = cfg.swap ? port_0 : port_1;

endmodule

`default_nettype wire

/* src/cart_detect.sv */
// Derives bank-switch scheme and Super Chip flag from the loaded file's extension
// Result is captured when a download starts and held until the next one
`timescale 1ns/1ps
`default_nettype none

module cart_detect (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               download,
	input  logic [8*a2600_cfg_pkg::EXT_CHARS-1:0] file_ext,
	input  a2600_cfg_pkg::sc_mode_e            sc_mode,
	output a2600_cfg_pkg::cart_t               cart
);
	import a2600_cfg_pkg::*;

	logic [8*(EXT_CHARS-1)-1:0] ext;
	logic                       dl_sync;
	logic                       dl_prev;
	bank_e                      bank_dec;
	logic                       sc_dec;

	// Dot in the second character means a two-letter extension in the low bytes
	assign ext = (file_ext[23:16] == ".") ? file_ext[23:0] : file_ext[31:8];

	always_comb begin
		case (ext)
			".F8":   bank_dec = bs_f8;
			".F6":   bank_dec = bs_f6;
			".FE":   bank_dec = bs_fe;
			".E0":   bank_dec = bs_e0;
			".3F":   bank_dec = bs_3f;
			".F4":   bank_dec = bs_f4;
			".P2":   bank_dec = bs_p2;
			".FA":   bank_dec = bs_fa;
			".CV":   bank_dec = bs_cv;
			".UA":   bank_dec = bs_ua;
			".E7":   bank_dec = bs_e7;
			".F0":   bank_dec = bs_f0;
			".32":   bank_dec = bs_32;
			default: bank_dec = bs_auto;
		endcase
	end

	// Auto mode looks for a trailing S, as in .F8S
	always_comb begin
		case (sc_mode)
			sc_enable:  sc_dec = 1'b1;
			sc_auto:    sc_dec = file_ext[7:0] == "S";
			default:    sc_dec = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_sync <= 1'b0;
			dl_prev <= 1'b0;
			cart    <= '{bank: bs_auto, superchip: 1'b0};
		end else begin
			dl_sync <= download;
			dl_prev <= dl_sync;
			if (dl_sync && !dl_prev)
				cart <= '{bank: bank_dec, superchip: sc_dec};
		end
	end

endmodule

`default_nettype wire

/* src/console_switches.sv */
// Console panel state: colour, difficulties and pause toggled from either pad
// Start and select pass straight through as active-low levels
`timescale 1ns/1ps
`default_nettype none

module console_switches (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  a2600_ctrl_pkg::pad_t     pad_0,
	input  a2600_ctrl_pkg::pad_t     pad_1,
	output a2600_ctrl_pkg::console_t console
);
	import a2600_ctrl_pkg::*;

	pad_t       pad_any;
	logic [2:0] sw_now;
	logic [2:0] sw_prev;
	logic [2:0] sw_rise;
	logic [1:0] pause_sync;
	logic       pause_prev;
	logic       color_q;
	logic [1:0] dif_q;
	logic       pause_q;

	// Either pad may work the panel
	assign pad_any = pad_0 | pad_1;
	assign sw_now  = {pad_any.sw_dif2, pad_any.sw_dif1, pad_any.sw_color};
	assign sw_rise = sw_now & ~sw_prev;

	// ========================================
	// Switch toggles
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sw_prev <= '0;
			color_q <= 1'b1;
			dif_q   <= '0;
		end else begin
			sw_prev <= sw_now;
			if (sw_rise[0])
				color_q <= ~color_q;
			// dif[0] is player 1, dif[1] player 2
			if (sw_rise[1])
				dif_q[0] <= ~dif_q[0];
			if (sw_rise[2])
				dif_q[1] <= ~dif_q[1];
		end
	end

	// Pause goes through a two-stage chain before the edge detect
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pause_sync <= '0;
			pause_prev <= 1'b0;
			pause_q    <= 1'b0;
		end else begin
			pause_sync <= {pause_sync[0], pad_any.pause};
			pause_prev <= pause_sync[1];
			if (pause_sync[1] && !pause_prev)
				pause_q <= ~pause_q;
		end
	end

	assign console.start_n  = ~pad_any.start;
	assign console.select_n = ~pad_any.select;
	assign console.color    = color_q;
	assign console.dif      = dif_q;
	assign console.pause    = pause_q;

endmodule

`default_nettype wire

/* src/paddle_port.sv */
// One player's paddle: picks knob, analog stick or mouse and drives the paddle value
// Instantiate once per port, has_mouse set only on the port wired to the mouse
`timescale 1ns/1ps
`default_nettype none

module paddle_port #(
	parameter bit has_mouse = 1'b0
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  a2600_ctrl_pkg::pad_t   pad,
	input  logic [15:0]            stick,
	input  logic [7:0]             knob,
	input  a2600_ctrl_pkg::mouse_t mouse,
	input  logic                   invert,
	output logic [7:0]             paddle,
	output logic                   button
);
	import a2600_ctrl_pkg::*;

	typedef enum logic [1:0] {
		src_knob,
		src_stick,
		src_mouse
	} src_e;

	src_e       src;
	logic       axis_y;
	logic [7:0] pre_out;
	logic [7:0] mouse_x;
	logic [7:0] mouse_y;
	logic       mouse_moved;

	generate
		if (has_mouse) begin : g_mouse
			mouse_tracker u_mouse (
				.clk_sys (clk_sys),
				.reset   (reset),
				.mouse   (mouse),
				.pos_x   (mouse_x),
				.pos_y   (mouse_y),
				.moved   (mouse_moved)
			);
		end else begin : g_no_mouse
			assign mouse_x     = '0;
			assign mouse_y     = '0;
			assign mouse_moved = 1'b0;
		end
	endgenerate

	// ========================================
	// Source and axis selection
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src    <= src_knob;
			axis_y <= 1'b0;
		end else begin
			// Later lines win, paddle button has the last word
			if (mouse_moved)
				src <= src_mouse;
			if (pad.stick_btn)
				src <= src_stick;
			if (pad.paddle_btn)
				src <= src_knob;

			if (src == src_stick) begin
				if (!stick[7] && stick[7:0] > STICK_AXIS_THRESH)
					axis_y <= 1'b0;
				if (!stick[15] && stick[15:8] > STICK_AXIS_THRESH)
					axis_y <= 1'b1;
			end else if (src == src_mouse) begin
				if (mouse.buttons[0])
					axis_y <= 1'b0;
				if (mouse.buttons[1])
					axis_y <= 1'b1;
			end
		end
	end

	// Value pipeline, two stages from source to pin
	always_ff @(posedge clk_sys) begin
		case (src)
			src_stick: pre_out <= axis_y ? stick[15:8] : stick[7:0];
			src_mouse: pre_out <= axis_y ? mouse_y : mouse_x;
			default:   pre_out <= {~knob[7], knob[6:0]};
		endcase
		paddle <= invert ? ~pre_out : pre_out;

		case (src)
			src_stick: button <= pad.stick_btn;
			src_mouse: button <= |mouse.buttons;
			default:   button <= pad.paddle_btn;
		endcase
	end

endmodule

`default_nettype wire

/* src/mouse_tracker.sv */
// Integrates mouse packets into a saturating two-axis position
// Used inside the paddle port that owns the mouse
`timescale 1ns/1ps
`default_nettype none

module mouse_tracker (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  a2600_ctrl_pkg::mouse_t mouse,
	output logic [7:0]             pos_x,
	output logic [7:0]             pos_y,
	output logic                   moved
);
	import a2600_ctrl_pkg::*;

	logic              strobe_q;
	logic              packet;
	logic signed [7:0] pos_x_q;
	logic signed [7:0] pos_y_q;
	logic signed [8:0] dx_step;
	logic signed [8:0] dy_step;
	logic signed [9:0] x_sum;
	logic signed [9:0] y_sum;

	// Limit one packet's motion so a fast flick does not jump the paddle
	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] d);
		if (d > MOUSE_STEP_MAX)
			return 9'(MOUSE_STEP_MAX);
		if (d < -MOUSE_STEP_MAX)
			return 9'(-MOUSE_STEP_MAX);
		return d;
	endfunction

	function automatic logic signed [7:0] saturate(input logic signed [9:0] s);
		if (s > 127)
			return 8'sh7f;
		if (s < -128)
			return 8'sh80;
		return s[7:0];
	endfunction

	assign packet  = mouse.strobe != strobe_q;
	assign dx_step = clamp_step({mouse.sign_x, mouse.dx});
	assign dy_step = clamp_step({mouse.sign_y, mouse.dy});
	assign x_sum   = {{2{pos_x_q[7]}}, pos_x_q} + {dx_step[8], dx_step};
	assign y_sum   = {{2{pos_y_q[7]}}, pos_y_q} + {dy_step[8], dy_step};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= 1'b0;
			pos_x_q  <= '0;
			pos_y_q  <= '0;
			moved    <= 1'b0;
		end else begin
			strobe_q <= mouse.strobe;
			moved    <= packet;
			if (packet) begin
				pos_x_q <= saturate(x_sum);
				pos_y_q <= saturate(y_sum);
			end
		end
	end

	assign pos_x = pos_x_q;
	assign pos_y = pos_y_q;

endmodule

`default_nettype wire

/* src/a2600_ctrl_pkg.sv */
// Controller, mouse and console panel signal bundles plus input thresholds
// Import where pads, players or the console panel are handled
`default_nettype none

package a2600_ctrl_pkg;

	// One pad, all buttons active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire;
		logic stick_btn;
		logic paddle_btn;
		logic start;
		logic select;
		logic pause;
		logic fire2;
		logic sw_color;
		logic sw_dif1;
		logic sw_dif2;
	} pad_t;

	// Mouse packet, a new packet toggles strobe
	typedef struct packed {
		logic       strobe;
		logic [7:0] dy;
		logic [7:0] dx;
		logic       sign_y;
		logic       sign_x;
		logic [1:0] buttons;
	} mouse_t;

	// What one player presents to the console, controls active low
	typedef struct packed {
		logic [3:0] dir_n;
		logic       fire_n;
		logic       fire2_n;
		logic       paddle_btn_n;
		logic [7:0] paddle;
	} player_t;

	typedef struct packed {
		logic       start_n;
		logic       select_n;
		logic       color;
		logic [1:0] dif;
		logic       pause;
	} console_t;

	localparam int MOUSE_STEP_MAX    = 10;
	localparam int STICK_AXIS_THRESH = 100;

endpackage

`default_nettype wire

/* src/a2600_cfg_pkg.sv */
// Cartridge and user configuration types shared by the cartridge detector and the top level
// Import where the bank-switch scheme or Super Chip setting is needed
`default_nettype none

package a2600_cfg_pkg;

	// ========================================
	// Bank-switch schemes
	// ========================================

	// Encoding matches the core's force_bs input, 10 is unused
	typedef enum logic [3:0] {
		bs_auto = 4'd0,
		bs_f8   = 4'd1,
		bs_f6   = 4'd2,
		bs_fe   = 4'd3,
		bs_e0   = 4'd4,
		bs_3f   = 4'd5,
		bs_f4   = 4'd6,
		bs_p2   = 4'd7,
		bs_fa   = 4'd8,
		bs_cv   = 4'd9,
		bs_ua   = 4'd11,
		bs_e7   = 4'd12,
		bs_f0   = 4'd13,
		bs_32   = 4'd14
	} bank_e;

	typedef enum logic [1:0] {
		sc_auto,
		sc_disable,
		sc_enable
	} sc_mode_e;

	// ========================================
	// Results and configuration
	// ========================================

	typedef struct packed {
		bank_e bank;
		logic  superchip;
	} cart_t;

	typedef struct packed {
		logic     swap;
		logic     invert_paddle;
		sc_mode_e sc_mode;
	} cfg_t;

	// ASCII characters carried in the file extension field
	localparam int EXT_CHARS = 4;

endpackage

`default_nettype wire
